//--- src/neo_loader_pkg.sv
package neo_loader_pkg;

	// Address widths
	localparam int IOCTL_AW = 27;
	localparam int PORT1_AW = 24;
	localparam int PORT2_AW = 26;

	// .NEO header layout
	localparam logic [IOCTL_AW-1:0] HEADER_LAST = 27'd4095;
	localparam logic [IOCTL_AW-1:0] SIZE_FIRST = 27'd4;
	localparam logic [IOCTL_AW-1:0] SIZE_LAST = 27'd27;

	// Upper address bits in bank 3
	localparam logic [4:0] FIX_PREFIX = 5'b11100;
	localparam logic [4:0] MROM_PREFIX = 5'b11110;

	// Silence for a disabled ADPCM channel
	localparam logic [7:0] ADPCM_IDLE_BYTE = 8'h80;

	// Regions in file order
	typedef enum logic [2:0] {
		REG_P,
		REG_S,
		REG_M,
		REG_V1,
		REG_V2,
		REG_C
	} rom_region_e;

	typedef enum logic [7:0] {
		IDX_CART = 8'd1,
		IDX_CART_NO_ADPCM = 8'd2
	} load_index_e;

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ACK_WAIT,
		WR_END_CHECK
	} wr_state_e;

endpackage

//--- src/neo_header_parser.sv
`timescale 1ns/10ps

module neo_header_parser import neo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst,
	input  logic                ioctl_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  load_index_e         ioctl_index,
	input  logic                cart_write,
	output logic [31:0]         p_size,
	output logic [31:0]         s_size,
	output logic [31:0]         m_size,
	output logic [31:0]         v1_size,
	output logic [31:0]         v2_size,
	output logic [31:0]         c_size,
	output logic [25:0]         v1_mask,
	output logic [25:0]         v2_mask,
	output logic [25:0]         c_mask,
	output logic [25:0]         v1_base,
	output logic [25:0]         v2_base,
	output logic                pcm_merged,
	output logic                adpcm_en,
	output logic                header_done
);

	logic header_byte;

	// Size rounded up to a power of two, minus one
	function automatic logic [25:0] size_mask(input logic [31:0] size);
		logic [31:0] m;
		m = size - 32'd1;
		for (int i = 1; i < 32; i = i * 2)
			m = m | (m >> i);
		if (size == 32'd0)
			m = 32'd0;
		return m[25:0];
	endfunction

	assign header_byte = cart_write && ioctl_wr && (ioctl_addr[IOCTL_AW-1:12] == '0);
	assign header_done = header_byte && (ioctl_addr == HEADER_LAST);

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			{c_size, v2_size, v1_size, m_size, s_size, p_size} <= '0;
			v1_mask <= '0;
			v2_mask <= '0;
			c_mask <= '0;
			pcm_merged <= 1'b0;
			adpcm_en <= 1'b0;
		end else begin
			// Little-endian sizes, P first
			if (header_byte && ioctl_addr >= SIZE_FIRST && ioctl_addr <= SIZE_LAST)
				{c_size, v2_size, v1_size, m_size, s_size, p_size} <=
					{ioctl_dout, c_size, v2_size, v1_size, m_size, s_size, p_size[31:8]};
			if (header_done)
				pcm_merged <= (v2_size == 32'd0);
			if (cart_write)
				adpcm_en <= (ioctl_index != IDX_CART_NO_ADPCM);
			v1_mask <= size_mask(v1_size);
			v2_mask <= size_mask(v2_size);
			c_mask <= size_mask(c_size);
		end
	end

	// Bank 0-2 holds C, then V1, then V2
	assign v1_base = c_size[25:0];
	assign v2_base = pcm_merged ? c_size[25:0] : c_size[25:0] + v1_size[25:0];

endmodule

//--- src/neo_region_sequencer.sv
`timescale 1ns/10ps

module neo_region_sequencer import neo_loader_pkg::*; (
	input  logic                CLK_48M,
	input  logic                rst,
	input  logic                ioctl_wr,
	input  logic [IOCTL_AW-1:0] ioctl_addr,
	input  logic [7:0]          ioctl_dout,
	input  logic                cart_write,
	input  logic                adpcm_en,
	input  logic                header_done,
	input  logic [31:0]         p_size,
	input  logic [31:0]         s_size,
	input  logic [31:0]         m_size,
	input  logic [31:0]         v1_size,
	input  logic [31:0]         v2_size,
	input  logic [31:0]         c_size,
	input  logic                p1_ack,
	input  logic                p2_ack,
	output logic                ioctl_busy,
	output logic                p1_req,
	output logic [PORT1_AW-1:0] p1_addr,
	output logic [1:0]          p1_ds,
	output logic [15:0]         p1_d,
	output logic                p2_req,
	output logic [PORT2_AW-1:0] p2_addr,
	output logic [1:0]          p2_ds,
	output logic [15:0]         p2_d
);

	wr_state_e           state;
	rom_region_e         region;
	logic [PORT2_AW-1:0] offset;
	logic [PORT2_AW-1:0] region_size;
	logic [PORT1_AW-1:0] p1_next;
	logic [PORT2_AW-1:0] p2_next;
	logic                on_p1;
	logic                is_pcm;
	logic                header_byte;
	logic                rom_byte;
	logic                ack_done;

	assign on_p1 = (region == REG_P) || (region == REG_S) || (region == REG_M);
	assign is_pcm = (region == REG_V1) || (region == REG_V2);
	assign header_byte = cart_write && ioctl_wr && (ioctl_addr[IOCTL_AW-1:12] == '0);
	assign rom_byte = cart_write && ioctl_wr && (ioctl_addr[IOCTL_AW-1:12] != '0);
	assign ack_done = on_p1 ? (p1_req == p1_ack) : (p2_req == p2_ack);
	assign ioctl_busy = (state != WR_IDLE);

	always_comb begin
		case (region)
			REG_P:   region_size = p_size[25:0];
			REG_S:   region_size = s_size[25:0];
			REG_M:   region_size = m_size[25:0];
			REG_V1:  region_size = v1_size[25:0];
			REG_V2:  region_size = v2_size[25:0];
			default: region_size = c_size[25:0];
		endcase
	end

	always_comb begin
		case (region)
			// FIX tiles are stored with a column swap
			REG_S:   p1_next = {FIX_PREFIX, offset[18:5], offset[2:0], ~offset[4], offset[3]};
			REG_M:   p1_next = {MROM_PREFIX, offset[18:0]};
			default: p1_next = offset[PORT1_AW-1:0];
		endcase
		case (region)
			REG_V1:  p2_next = c_size[25:0] + offset;
			REG_V2:  p2_next = c_size[25:0] + v1_size[25:0] + offset;
			// C bytes interleave the odd and even sprite planes
			default: p2_next = {offset[25:7], ioctl_addr[5:2], ~ioctl_addr[6], ioctl_addr[0],
				ioctl_addr[1]};
		endcase
	end

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			state <= WR_IDLE;
			region <= REG_P;
			offset <= '0;
			p1_req <= 1'b0;
			p2_req <= 1'b0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (header_byte) begin
						region <= REG_P;
						offset <= '0;
						if (header_done)
							state <= WR_END_CHECK;
					end else if (rom_byte) begin
						state <= WR_ACK_WAIT;
						if (on_p1) begin
							p1_req <= ~p1_req;
							p1_addr <= p1_next;
							p1_ds <= {p1_next[0], ~p1_next[0]};
							p1_d <= {ioctl_dout, ioctl_dout};
						end else if (adpcm_en || !is_pcm) begin
							p2_req <= ~p2_req;
							p2_addr <= p2_next;
							p2_ds <= {p2_next[0], ~p2_next[0]};
							p2_d <= {ioctl_dout, ioctl_dout};
						end
					end
				end
				WR_ACK_WAIT: begin
					if (ack_done) begin
						offset <= offset + 1'b1;
						state <= WR_END_CHECK;
					end
				end
				WR_END_CHECK: begin
					// Empty regions are stepped over here, one per cycle
					if (offset == region_size) begin
						offset <= '0;
						if (region == REG_C)
							state <= WR_IDLE;
						else
							region <= rom_region_e'(region + 3'd1);
					end else begin
						state <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

endmodule

//--- src/adpcm_fetch.sv
`timescale 1ns/10ps

module adpcm_fetch import neo_loader_pkg::*; #(
	parameter int SAMPLE_AW = 26
) (
	input  logic                 CLK_48M,
	input  logic                 rst,
	input  logic                 rd,
	input  logic [23:0]          raw_addr,
	input  logic                 pcm_merged,
	input  logic [25:0]          addr_mask,
	input  logic [25:0]          alt_mask,
	input  logic [25:0]          base,
	input  logic                 enable,
	input  logic                 ack,
	input  logic [31:0]          q,
	output logic                 req,
	output logic [SAMPLE_AW-1:0] addr,
	output logic [7:0]           data,
	output logic                 ready
);

	logic        rd_d;
	logic [23:0] latch;
	logic [23:0] masked;
	logic [25:0] mask;
	logic [25:0] sum;

	// Merged images keep ADPCM-B inside the V1 area
	assign mask = pcm_merged ? alt_mask : addr_mask;
	assign masked = raw_addr & mask[23:0];

	always_ff @(posedge CLK_48M) begin
		if (rst) begin
			rd_d <= 1'b0;
			req <= 1'b0;
			latch <= '0;
		end else begin
			rd_d <= rd;
			if (rd && !rd_d && enable) begin
				// New dword only
				if (masked[23:2] != latch[23:2])
					req <= ~req;
				latch <= masked;
			end
		end
	end

	assign sum = base + {2'b00, latch};
	assign addr = sum[SAMPLE_AW-1:0];
	assign ready = (req == ack);

	always_comb begin
		if (!enable) begin
			data = ADPCM_IDLE_BYTE;
		end else begin
			case (latch[1:0])
				2'd0:    data = q[7:0];
				2'd1:    data = q[15:8];
				2'd2:    data = q[23:16];
				default: data = q[31:24];
			endcase
		end
	end

endmodule

//--- src/neo_cart_loader.sv
`timescale 1ns/10ps

module neo_cart_loader import neo_loader_pkg::*; #(
	parameter int SAMPLE_AW = 26
) (
	input  logic                 CLK_48M,
	input  logic                 rst,
	input  logic                 ioctl_download,
	input  logic [7:0]           ioctl_index,
	input  logic                 ioctl_wr,
	input  logic [IOCTL_AW-1:0]  ioctl_addr,
	input  logic [7:0]           ioctl_dout,
	output logic                 ioctl_busy,
	output logic                 p1_req,
	input  logic                 p1_ack,
	output logic [PORT1_AW-1:0]  p1_addr,
	output logic [1:0]           p1_ds,
	output logic [15:0]          p1_d,
	output logic                 p2_req,
	input  logic                 p2_ack,
	output logic [PORT2_AW-1:0]  p2_addr,
	output logic [1:0]           p2_ds,
	output logic [15:0]          p2_d,
	input  logic                 adpcma_rd,
	input  logic [3:0]           adpcma_bank,
	input  logic [19:0]          adpcma_addr,
	output logic [7:0]           adpcma_data,
	output logic                 adpcma_ready,
	input  logic                 adpcmb_rd,
	input  logic [23:0]          adpcmb_addr,
	output logic [7:0]           adpcmb_data,
	output logic                 adpcmb_ready,
	output logic                 sample_a_req,
	input  logic                 sample_a_ack,
	output logic [SAMPLE_AW-1:0] sample_a_addr,
	input  logic [31:0]          sample_a_q,
	output logic                 sample_b_req,
	input  logic                 sample_b_ack,
	output logic [SAMPLE_AW-1:0] sample_b_addr,
	input  logic [31:0]          sample_b_q
);

	logic        cart_write;
	logic [31:0] p_size, s_size, m_size, v1_size, v2_size, c_size;
	logic [25:0] v1_mask, v2_mask;
	logic [25:0] v1_base, v2_base;
	logic        pcm_merged, adpcm_en, header_done;

	// Both cart indices share the loader
	assign cart_write = ioctl_download &&
		(ioctl_index == IDX_CART || ioctl_index == IDX_CART_NO_ADPCM);

	neo_header_parser u_header (
		.CLK_48M(CLK_48M), .rst(rst), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_index(load_index_e'(ioctl_index)),
		.cart_write(cart_write), .p_size(p_size), .s_size(s_size), .m_size(m_size),
		.v1_size(v1_size), .v2_size(v2_size), .c_size(c_size), .v1_mask(v1_mask),
		.v2_mask(v2_mask), .c_mask(), .v1_base(v1_base), .v2_base(v2_base),
		.pcm_merged(pcm_merged), .adpcm_en(adpcm_en), .header_done(header_done)
	);

	neo_region_sequencer u_seq (
		.CLK_48M(CLK_48M), .rst(rst), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .cart_write(cart_write), .adpcm_en(adpcm_en),
		.header_done(header_done), .p_size(p_size), .s_size(s_size), .m_size(m_size),
		.v1_size(v1_size), .v2_size(v2_size), .c_size(c_size), .p1_ack(p1_ack),
		.p2_ack(p2_ack), .ioctl_busy(ioctl_busy), .p1_req(p1_req), .p1_addr(p1_addr),
		.p1_ds(p1_ds), .p1_d(p1_d), .p2_req(p2_req), .p2_addr(p2_addr), .p2_ds(p2_ds),
		.p2_d(p2_d)
	);

	// Channel A always lives in V1
	adpcm_fetch #(.SAMPLE_AW(SAMPLE_AW)) u_adpcm_a (
		.CLK_48M(CLK_48M), .rst(rst), .rd(adpcma_rd), .raw_addr({adpcma_bank, adpcma_addr}),
		.pcm_merged(pcm_merged), .addr_mask(v1_mask), .alt_mask(v1_mask), .base(v1_base),
		.enable(adpcm_en), .ack(sample_a_ack), .q(sample_a_q), .req(sample_a_req),
		.addr(sample_a_addr), .data(adpcma_data), .ready(adpcma_ready)
	);

	adpcm_fetch #(.SAMPLE_AW(SAMPLE_AW)) u_adpcm_b (
		.CLK_48M(CLK_48M), .rst(rst), .rd(adpcmb_rd), .raw_addr(adpcmb_addr),
		.pcm_merged(pcm_merged), .addr_mask(v2_mask), .alt_mask(v1_mask), .base(v2_base),
		.enable(adpcm_en), .ack(sample_b_ack), .q(sample_b_q), .req(sample_b_req),
		.addr(sample_b_addr), .data(adpcmb_data), .ready(adpcmb_ready)
	);

endmodule

//--- sim/neo_loader_sva.sv
`timescale 1ns/10ps

module neo_loader_sva (
	input logic        CLK_48M,
	input logic        rst,
	input logic        ioctl_busy,
	input logic        p1_req,
	input logic        p1_ack,
	input logic [23:0] p1_addr,
	input logic        p2_req,
	input logic        p2_ack,
	input logic [25:0] p2_addr
);

	int assert_fails = 0;

	// A pending request holds its toggle and its address
	p1_hold: assert property (@(posedge CLK_48M) disable iff (rst)
		(p1_req != p1_ack) |=> $stable(p1_req) && $stable(p1_addr))
		else begin
			assert_fails++;
			$error("p1 request or address changed while pending");
		end

	p2_hold: assert property (@(posedge CLK_48M) disable iff (rst)
		(p2_req != p2_ack) |=> $stable(p2_req) && $stable(p2_addr))
		else begin
			assert_fails++;
			$error("p2 request or address changed while pending");
		end

	busy_reset: assert property (@(posedge CLK_48M) rst |=> !ioctl_busy)
		else begin
			assert_fails++;
			$error("ioctl_busy high after reset");
		end

endmodule

//--- sim/neo_loader_checker.sv
`timescale 1ns/10ps

module neo_loader_checker (
	input logic        CLK_48M,
	input logic        rst,
	input logic        p1_req,
	input logic [23:0] p1_addr,
	input logic [1:0]  p1_ds,
	input logic [15:0] p1_d,
	input logic        p2_req,
	input logic [25:0] p2_addr,
	input logic [1:0]  p2_ds,
	input logic [15:0] p2_d
);

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int failed_tests = 0;
	int test_errors = 0;
	int test_checks = 0;
	// Entries are address, strobes, data
	logic [43:0] exp1[$];
	logic [43:0] exp2[$];
	logic p1_last, p2_last;

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic expect_write(input int port, input logic [25:0] addr, input logic [1:0] ds,
		input logic [15:0] d);
		if (port == 1)
			exp1.push_back({addr, ds, d});
		else
			exp2.push_back({addr, ds, d});
	endtask

	task automatic compare_write(input int port, input logic [43:0] got);
		logic [43:0] want;
		checks++;
		test_checks++;
		if ((port == 1 && exp1.size() == 0) || (port == 2 && exp2.size() == 0)) begin
			$display("[ERROR] %0t: p%0d write to %h issued but no write was expected",
				$time, port, got[43:18]);
			count_error();
		end else begin
			if (port == 1)
				want = exp1.pop_front();
			else
				want = exp2.pop_front();
			if (got !== want) begin
				$display("[ERROR] %0t: p%0d addr %h ds %b d %h, expected addr %h ds %b d %h",
					$time, port, got[43:18], got[17:16], got[15:0],
					want[43:18], want[17:16], want[15:0]);
				count_error();
			end
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		test_checks++;
		if (got !== want) begin
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, want);
			count_error();
		end
	endtask

	task automatic end_test(input string name);
		if (exp1.size() + exp2.size() != 0) begin
			$display("[ERROR] %0t: %0d expected writes were never issued",
				$time, exp1.size() + exp2.size());
			count_error();
			exp1.delete();
			exp2.delete();
		end
		tests++;
		if (test_errors == 0) begin
			$display("test %s: ok, %0d checks", name, test_checks);
		end else begin
			failed_tests++;
			$display("test %s: failed with %0d errors", name, test_errors);
		end
		test_errors = 0;
		test_checks = 0;
	endtask

	task automatic print_totals();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests, failed_tests, checks, errors);
	endtask

	// Toggles are stable by the falling edge
	always @(negedge CLK_48M) begin
		if (rst) begin
			p1_last = p1_req;
			p2_last = p2_req;
		end else begin
			if (p1_req !== p1_last)
				compare_write(1, {2'b00, p1_addr, p1_ds, p1_d});
			if (p2_req !== p2_last)
				compare_write(2, {p2_addr, p2_ds, p2_d});
			p1_last = p1_req;
			p2_last = p2_req;
		end
	end

endmodule

//--- sim/tb_neo_cart_loader.sv
`timescale 1ns/10ps

module tb_neo_cart_loader;

	localparam int WAIT_LIMIT = 1000;

	logic        CLK_48M, rst, ioctl_download, ioctl_wr, ioctl_busy;
	logic [7:0]  ioctl_index, ioctl_dout;
	logic [26:0] ioctl_addr;
	logic        p1_req, p2_req;
	logic [23:0] p1_addr;
	logic [25:0] p2_addr;
	logic [1:0]  p1_ds, p2_ds;
	logic [15:0] p1_d, p2_d;
	logic        adpcma_rd, adpcmb_rd, adpcma_ready, adpcmb_ready;
	logic [3:0]  adpcma_bank;
	logic [19:0] adpcma_addr;
	logic [23:0] adpcmb_addr;
	logic [7:0]  adpcma_data, adpcmb_data;
	logic        sample_a_req, sample_b_req;
	logic [25:0] sample_a_addr, sample_b_addr;
	logic [31:0] sample_a_q, sample_b_q;
	// Acks in the order p1, p2, sample A, sample B
	logic [3:0]  acks;
	logic [3:0]  reqs;
	int          delay [4];
	int          sizes [6];
	logic [21:0] last_dw [2];
	int          seed;

	neo_cart_loader #(.SAMPLE_AW(26)) u_neo_cart_loader (
		.CLK_48M(CLK_48M), .rst(rst), .ioctl_download(ioctl_download),
		.ioctl_index(ioctl_index), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_busy(ioctl_busy), .p1_req(p1_req), .p1_ack(acks[0]),
		.p1_addr(p1_addr), .p1_ds(p1_ds), .p1_d(p1_d), .p2_req(p2_req), .p2_ack(acks[1]),
		.p2_addr(p2_addr), .p2_ds(p2_ds), .p2_d(p2_d), .adpcma_rd(adpcma_rd),
		.adpcma_bank(adpcma_bank), .adpcma_addr(adpcma_addr), .adpcma_data(adpcma_data),
		.adpcma_ready(adpcma_ready), .adpcmb_rd(adpcmb_rd), .adpcmb_addr(adpcmb_addr),
		.adpcmb_data(adpcmb_data), .adpcmb_ready(adpcmb_ready), .sample_a_req(sample_a_req),
		.sample_a_ack(acks[2]), .sample_a_addr(sample_a_addr), .sample_a_q(sample_a_q),
		.sample_b_req(sample_b_req), .sample_b_ack(acks[3]), .sample_b_addr(sample_b_addr),
		.sample_b_q(sample_b_q)
	);

	neo_loader_checker u_checker (
		.CLK_48M(CLK_48M), .rst(rst), .p1_req(p1_req), .p1_addr(p1_addr), .p1_ds(p1_ds),
		.p1_d(p1_d), .p2_req(p2_req), .p2_addr(p2_addr), .p2_ds(p2_ds), .p2_d(p2_d)
	);

	bind neo_region_sequencer neo_loader_sva u_sva (
		.CLK_48M(CLK_48M), .rst(rst), .ioctl_busy(ioctl_busy), .p1_req(p1_req),
		.p1_ack(p1_ack), .p1_addr(p1_addr), .p2_req(p2_req), .p2_ack(p2_ack),
		.p2_addr(p2_addr)
	);

	always #2 CLK_48M = ~CLK_48M;

	assign reqs = {sample_b_req, sample_a_req, p2_req, p1_req};

	// Sample memory content per dword
	function automatic logic [31:0] word_at(input logic [25:0] a);
		return {~a[9:2], a[25:2]};
	endfunction

	// Memory ports answer after a random number of cycles
	always @(posedge CLK_48M) begin
		#1;
		for (int i = 0; i < 4; i++) begin
			if (reqs[i] != acks[i]) begin
				if (delay[i] == 0) begin
					if (i == 2)
						sample_a_q = word_at(sample_a_addr);
					if (i == 3)
						sample_b_q = word_at(sample_b_addr);
					acks[i] = ~acks[i];
					delay[i] = $random(seed) & 3;
				end else begin
					delay[i] = delay[i] - 1;
				end
			end
		end
	end

	// Port, byte strobes and address of one ROM byte
	function automatic logic [29:0] expected_write(input int region, input logic [25:0] off,
		input logic [26:0] a);
		logic [25:0] ad;
		logic [1:0]  port;
		port = (region < 3) ? 2'd1 : 2'd2;
		case (region)
			0:       ad = {2'b00, off[23:0]};
			1:       ad = {2'b00, 5'b11100, off[18:5], off[2:0], ~off[4], off[3]};
			2:       ad = {2'b00, 5'b11110, off[18:0]};
			3:       ad = 26'(sizes[5]) + off;
			4:       ad = 26'(sizes[5]) + 26'(sizes[3]) + off;
			default: ad = {off[25:7], a[5:2], ~a[6], a[0], a[1]};
		endcase
		return {port, ad[0], ~ad[0], ad};
	endfunction

	function automatic logic [25:0] pow2_mask(input int size);
		int m;
		m = 1;
		while (m < size)
			m = m * 2;
		return 26'(m - 1);
	endfunction

	task automatic abort_on_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("FAIL: see errors above");
		$finish;
	endtask

	task automatic wait_idle();
		int t;
		t = 0;
		while (ioctl_busy) begin
			t++;
			if (t > WAIT_LIMIT)
				abort_on_timeout("ioctl_busy to fall");
			@(posedge CLK_48M);
			#1;
		end
	endtask

	task automatic send_byte(input logic [26:0] a, input logic [7:0] d);
		wait_idle();
		ioctl_addr = a;
		ioctl_dout = d;
		ioctl_wr = 1'b1;
		@(posedge CLK_48M);
		#1;
		ioctl_wr = 1'b0;
	endtask

	task automatic set_sizes(input int p, input int s, input int m, input int v1, input int v2,
		input int c);
		sizes[0] = p;
		sizes[1] = s;
		sizes[2] = m;
		sizes[3] = v1;
		sizes[4] = v2;
		sizes[5] = c;
	endtask

	task automatic load_cart(input logic [7:0] index);
		logic [26:0] a;
		logic [29:0] w;
		logic [7:0]  d;
		ioctl_index = index;
		ioctl_download = 1'b1;
		for (int i = 0; i < 4096; i++) begin
			d = (i >= 4 && i < 28) ? 8'(sizes[(i - 4) / 4] >> (8 * ((i - 4) % 4))) : 8'h00;
			send_byte(27'(i), d);
		end
		a = 27'd4096;
		for (int r = 0; r < 6; r++) begin
			for (int off = 0; off < sizes[r]; off++) begin
				d = 8'($random(seed));
				w = expected_write(r, 26'(off), a);
				// Without ADPCM the V1 and V2 bytes are dropped
				if (!(index == 8'd2 && (r == 3 || r == 4)))
					u_checker.expect_write(int'(w[29:28]), w[25:0], w[27:26], {d, d});
				send_byte(a, d);
				a = a + 27'd1;
			end
		end
		wait_idle();
		ioctl_download = 1'b0;
	endtask

	task automatic read_samples(input int ch, input int n, input logic [25:0] mask,
		input logic [25:0] base);
		logic [23:0] raw, m;
		logic [25:0] ea;
		logic        req_before;
		int          t;
		for (int k = 0; k < n; k++) begin
			// First read of a batch always fetches a new dword
			do begin
				raw = 24'($random(seed));
				m = raw & mask[23:0];
			end while (k == 0 && m[23:2] == last_dw[ch]);
			ea = base + {2'b00, m};
			req_before = ch ? sample_b_req : sample_a_req;
			if (ch == 1) begin
				adpcmb_addr = raw;
				adpcmb_rd = 1'b1;
			end else begin
				{adpcma_bank, adpcma_addr} = raw;
				adpcma_rd = 1'b1;
			end
			@(posedge CLK_48M);
			#1;
			u_checker.check_value("fetch request", 32'((ch ? sample_b_req : sample_a_req)
				!= req_before), 32'(m[23:2] != last_dw[ch]));
			// Same dword keeps ready high
			if (m[23:2] == last_dw[ch])
				u_checker.check_value("ready without fetch",
					32'(ch ? adpcmb_ready : adpcma_ready), 32'd1);
			last_dw[ch] = m[23:2];
			// Ready and data settle by the falling edge
			t = 0;
			@(negedge CLK_48M);
			while (!(ch ? adpcmb_ready : adpcma_ready)) begin
				t++;
				if (t > WAIT_LIMIT)
					abort_on_timeout("ADPCM ready");
				@(negedge CLK_48M);
			end
			u_checker.check_value("sample address", 32'(ch ? sample_b_addr : sample_a_addr),
				32'(ea));
			u_checker.check_value("sample byte", 32'(ch ? adpcmb_data : adpcma_data),
				32'(8'(word_at(ea) >> (8 * m[1:0]))));
			@(posedge CLK_48M);
			#1;
			adpcma_rd = 1'b0;
			adpcmb_rd = 1'b0;
			@(posedge CLK_48M);
			#1;
		end
	endtask

	initial begin
		seed = 94103;
		CLK_48M = 1'b0;
		rst = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = 8'd0;
		adpcma_rd = 1'b0;
		adpcma_bank = 4'd0;
		adpcma_addr = 20'd0;
		adpcmb_rd = 1'b0;
		adpcmb_addr = 24'd0;
		acks = 4'b0000;
		sample_a_q = 32'd0;
		sample_b_q = 32'd0;
		last_dw[0] = '0;
		last_dw[1] = '0;
		for (int i = 0; i < 4; i++)
			delay[i] = 0;
		repeat (16) @(posedge CLK_48M);
		#1;
		rst = 1'b0;

		set_sizes(24, 40, 20, 36, 28, 256);
		load_cart(8'd1);
		u_checker.end_test("full cartridge");
		read_samples(0, 12, pow2_mask(sizes[3]), 26'(sizes[5]));
		u_checker.end_test("adpcm a fetch");
		read_samples(1, 12, pow2_mask(sizes[4]), 26'(sizes[5] + sizes[3]));
		u_checker.end_test("adpcm b with v2");

		// S and V2 empty, so PCM is merged
		set_sizes(16, 0, 12, 32, 0, 128);
		load_cart(8'd1);
		u_checker.end_test("empty s and v2");
		read_samples(1, 12, pow2_mask(sizes[3]), 26'(sizes[5]));
		u_checker.end_test("adpcm b merged");

		set_sizes(8, 16, 8, 20, 12, 128);
		load_cart(8'd2);
		u_checker.check_value("adpcma_data", 32'(adpcma_data), 32'h80);
		u_checker.check_value("adpcmb_data", 32'(adpcmb_data), 32'h80);
		u_checker.end_test("no adpcm load");

		u_checker.print_totals();
		if (u_checker.errors == 0 && u_neo_cart_loader.u_seq.u_sva.assert_fails == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

//--- neo_cart_loader.f
src/neo_loader_pkg.sv
src/neo_header_parser.sv
src/neo_region_sequencer.sv
src/adpcm_fetch.sv
src/neo_cart_loader.sv
sim/neo_loader_sva.sv
sim/neo_loader_checker.sv
sim/tb_neo_cart_loader.sv

//--- Bender.yml
package:
  name: neo_cart_loader

sources:
  - src/neo_loader_pkg.sv
  - src/neo_header_parser.sv
  - src/neo_region_sequencer.sv
  - src/adpcm_fetch.sv
  - src/neo_cart_loader.sv
  - target: simulation
    files:
      - sim/neo_loader_sva.sv
      - sim/neo_loader_checker.sv
      - sim/tb_neo_cart_loader.sv
